// File: src/noc_shim_cfg.svh
`ifndef NOC_SHIM_CFG_SVH
`define NOC_SHIM_CFG_SVH

// Stream word and flit geometry
`define NOC_WORD_WIDTH 64
`define NOC_SER_FACTOR 4
`define NOC_FLIT_WIDTH (`NOC_WORD_WIDTH / `NOC_SER_FACTOR)

// Sideband fields carried on every flit
`define NOC_DEST_WIDTH 3
`define NOC_USER_WIDTH 8

// Buffer sizes on both ends of the link
`define NOC_INJ_DEPTH 4
`define NOC_EJ_DEPTH 8

// Credits held by the sender after reset
`define NOC_LINK_CREDITS 4

`endif

// File: src/noc_shim_pkg.sv
`include "noc_shim_cfg.svh"

package noc_shim_pkg;

    // Full stream word as seen on the user ports
    typedef struct packed {
        logic [`NOC_WORD_WIDTH-1:0] data;
        logic [`NOC_DEST_WIDTH-1:0] dest;
        logic [`NOC_USER_WIDTH-1:0] user;
        logic                       last;
    } axis_word_t;

    // One slice of a word on the link
    typedef struct packed {
        logic [`NOC_FLIT_WIDTH-1:0] data;
        logic [`NOC_DEST_WIDTH-1:0] dest;
        logic [`NOC_USER_WIDTH-1:0] user;
        logic                       tail;
    } flit_t;

endpackage

// File: src/flit_fifo.sv
module flit_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  depth   = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  entry_t                 push_data,
    input  logic                   pop,
    output entry_t                 head,
    output logic                   empty,
    output logic                   full,
    output logic [$clog2(depth):0] count
);
    localparam int AW = (depth > 1) ? $clog2(depth) : 1;

    entry_t        mem [depth];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_push;
    logic          do_pop;

    assign empty   = (count == '0);
    assign full    = (count == ($clog2(depth) + 1)'(depth));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Show-ahead read
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + ($clog2(depth) + 1)'(do_push) - ($clog2(depth) + 1)'(do_pop);
        end
    end

endmodule

// File: src/word_serializer.sv
`include "noc_shim_cfg.svh"

module word_serializer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  noc_shim_pkg::axis_word_t in_word,
    output logic                     flit_valid,
    input  logic                     flit_ready,
    output noc_shim_pkg::flit_t      flit
);
    import noc_shim_pkg::*;

    localparam int SER   = `NOC_SER_FACTOR;
    localparam int FW    = `NOC_FLIT_WIDTH;
    localparam int CNT_W = $clog2(SER);

    axis_word_t       word_q;
    logic [CNT_W-1:0] slice_cnt;
    logic             last_slice;
    logic             flit_xfer;

    assign last_slice = (slice_cnt == CNT_W'(SER - 1));
    assign flit_xfer  = flit_valid && flit_ready;

    // Next word may enter as the final slice of the current one leaves
    assign in_ready = !flit_valid || (flit_xfer && last_slice);

    always_comb begin
        flit.data = word_q.data[slice_cnt * FW +: FW];
        flit.dest = word_q.dest;
        flit.user = word_q.user;
        flit.tail = word_q.last && last_slice;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            word_q <= in_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flit_valid <= 1'b0;
            slice_cnt  <= '0;
        end else begin
            if (flit_xfer) begin
                slice_cnt <= last_slice ? '0 : slice_cnt + 1'b1;
                if (last_slice) begin
                    flit_valid <= 1'b0;
                end
            end
            if (in_valid && in_ready) begin
                flit_valid <= 1'b1;
            end
        end
    end

endmodule

// File: src/flit_injector.sv
`include "noc_shim_cfg.svh"

module flit_injector (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flit_valid,
    output logic                flit_ready,
    input  noc_shim_pkg::flit_t flit,
    output logic                link_send,
    output noc_shim_pkg::flit_t link_flit,
    input  logic                link_credit
);
    import noc_shim_pkg::*;

    localparam int CRD_W = $clog2(`NOC_LINK_CREDITS) + 1;

    flit_t            fifo_head;
    logic             fifo_empty;
    logic             fifo_full;
    logic             pop;
    logic [CRD_W-1:0] credit_count;

    assign flit_ready = !fifo_full;

    // Only drain the buffer while the far side has room
    assign pop = (credit_count != '0) && !fifo_empty;

    flit_fifo #(
        .entry_t (flit_t),
        .depth   (`NOC_INJ_DEPTH)
    ) u_inj_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (flit_valid && flit_ready),
        .push_data (flit),
        .pop       (pop),
        .head      (fifo_head),
        .empty     (fifo_empty),
        .full      (fifo_full),
        .count     ()
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_count <= CRD_W'(`NOC_LINK_CREDITS);
            link_send    <= 1'b0;
        end else begin
            credit_count <= credit_count + CRD_W'(link_credit) - CRD_W'(pop);
            link_send    <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            link_flit <= fifo_head;
        end
    end

endmodule

// File: src/flit_ejector.sv
`include "noc_shim_cfg.svh"

module flit_ejector (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                link_send,
    input  noc_shim_pkg::flit_t link_flit,
    output logic                link_credit,
    output logic                flit_valid,
    input  logic                flit_ready,
    output noc_shim_pkg::flit_t flit
);
    import noc_shim_pkg::*;

    localparam int EJ_DEPTH = `NOC_EJ_DEPTH;
    localparam int CREDITS  = `NOC_LINK_CREDITS;
    localparam int OCC_W    = $clog2(EJ_DEPTH) + 1;
    localparam int CRD_W    = $clog2(CREDITS) + 1;
    localparam int SUM_W    = ((OCC_W > CRD_W) ? OCC_W : CRD_W) + 1;

    logic             fifo_empty;
    logic             pop;
    logic [OCC_W-1:0] occupancy;
    logic [CRD_W-1:0] credit_count;
    logic [SUM_W-1:0] committed;
    logic             room;

    assign flit_valid = !fifo_empty;
    assign pop        = flit_valid && flit_ready;

    // Entries in use plus flits the sender may still launch
    assign committed = SUM_W'(occupancy) + SUM_W'(credit_count);
    assign room      = committed < (SUM_W'(EJ_DEPTH) + SUM_W'(pop));

    assign link_credit = ((credit_count < CRD_W'(CREDITS)) || link_send) && room;

    flit_fifo #(
        .entry_t (flit_t),
        .depth   (EJ_DEPTH)
    ) u_ej_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (link_send),
        .push_data (link_flit),
        .pop       (pop),
        .head      (flit),
        .empty     (fifo_empty),
        .full      (),
        .count     (occupancy)
    );

    // Mirror of the credits held on the sending side
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_count <= CRD_W'(CREDITS);
        end else begin
            credit_count <= credit_count + CRD_W'(link_credit) - CRD_W'(link_send);
        end
    end

endmodule

// File: src/word_deserializer.sv
`include "noc_shim_cfg.svh"

module word_deserializer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flit_valid,
    output logic                     flit_ready,
    input  noc_shim_pkg::flit_t      flit,
    output logic                     out_valid,
    input  logic                     out_ready,
    output noc_shim_pkg::axis_word_t out_word
);
    localparam int SER   = `NOC_SER_FACTOR;
    localparam int FW    = `NOC_FLIT_WIDTH;
    localparam int CNT_W = $clog2(SER);

    logic [CNT_W-1:0] slice_cnt;
    logic             last_slice;
    logic             flit_xfer;
    logic             word_taken;

    assign last_slice = (slice_cnt == CNT_W'(SER - 1));
    assign word_taken = out_valid && out_ready;
    assign flit_ready = !out_valid || word_taken;
    assign flit_xfer  = flit_valid && flit_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slice_cnt <= '0;
            out_valid <= 1'b0;
        end else begin
            if (flit_xfer) begin
                slice_cnt <= last_slice ? '0 : slice_cnt + 1'b1;
            end
            if (word_taken) begin
                out_valid <= 1'b0;
            end
            if (flit_xfer && last_slice) begin
                out_valid <= 1'b1;
            end
        end
    end

    // Slices land lowest first, sideband comes with the final flit
    always_ff @(posedge clk) begin
        if (flit_xfer) begin
            out_word.data[slice_cnt * FW +: FW] <= flit.data;
            if (last_slice) begin
                out_word.dest <= flit.dest;
                out_word.user <= flit.user;
                out_word.last <= flit.tail;
            end
        end
    end

endmodule

// File: src/noc_shim_loopback.sv
module noc_shim_loopback (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  noc_shim_pkg::axis_word_t in_word,
    output logic                     out_valid,
    input  logic                     out_ready,
    output noc_shim_pkg::axis_word_t out_word
);
    import noc_shim_pkg::*;

    // Producer side
    logic  ser_valid;
    logic  ser_ready;
    flit_t ser_flit;

    // Link
    logic  link_send;
    flit_t link_flit;
    logic  link_credit;

    // Consumer side
    logic  ej_valid;
    logic  ej_ready;
    flit_t ej_flit;

    word_serializer u_serializer (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_word    (in_word),
        .flit_valid (ser_valid),
        .flit_ready (ser_ready),
        .flit       (ser_flit)
    );

    flit_injector u_injector (
        .clk         (clk),
        .rst_n       (rst_n),
        .flit_valid  (ser_valid),
        .flit_ready  (ser_ready),
        .flit        (ser_flit),
        .link_send   (link_send),
        .link_flit   (link_flit),
        .link_credit (link_credit)
    );

    flit_ejector u_ejector (
        .clk         (clk),
        .rst_n       (rst_n),
        .link_send   (link_send),
        .link_flit   (link_flit),
        .link_credit (link_credit),
        .flit_valid  (ej_valid),
        .flit_ready  (ej_ready),
        .flit        (ej_flit)
    );

    word_deserializer u_deserializer (
        .clk        (clk),
        .rst_n      (rst_n),
        .flit_valid (ej_valid),
        .flit_ready (ej_ready),
        .flit       (ej_flit),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_word   (out_word)
    );

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int period = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(period / 2) clk = ~clk;

endmodule

// File: sim/noc_shim_assertions.sv
`include "noc_shim_cfg.svh"

module noc_shim_assertions (
    input logic                                  clk,
    input logic                                  rst_n,
    input logic                                  link_send,
    input logic [$clog2(`NOC_LINK_CREDITS):0]    credit_count
);

    // A send comes from a pop, which needs a credit in the cycle before
    send_needs_credit: assert property (
        @(posedge clk) disable iff (!rst_n)
        link_send |-> ($past(credit_count) != '0)
    ) else $error("link_send without a credit in the previous cycle");

    credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        credit_count <= ($clog2(`NOC_LINK_CREDITS) + 1)'(`NOC_LINK_CREDITS)
    ) else $error("credit count above the link credit limit");

    // Second reset cycle onward, the send register must be cleared
    no_send_in_reset: assert property (
        @(posedge clk)
        (!rst_n && $past(!rst_n)) |-> !link_send
    ) else $error("link_send high during reset");

endmodule

bind flit_injector noc_shim_assertions u_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .link_send    (link_send),
    .credit_count (credit_count)
);

// File: sim/noc_shim_tb.sv
module noc_shim_tb;
    import noc_shim_pkg::*;

    localparam int clk_period     = 8;
    localparam int num_words      = 200;
    localparam int watchdog_limit = num_words * 200 * clk_period;
    // The serializer alone keeps in_ready low for only three cycles per word
    localparam int blocked_limit  = 12;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    axis_word_t in_word;
    logic       out_valid;
    logic       out_ready;
    axis_word_t out_word;

    int         seed;
    axis_word_t model_q[$];
    axis_word_t expected;
    int         offered;
    int         sent;
    int         received;
    int         stall_left;
    int         blocked_run;
    int         last_set_seen;
    int         last_clear_seen;
    bit         backpressure_seen;
    bit         in_fire;
    bit         out_fire;
    int         word_errors;
    int         idle_errors;
    int         other_errors;

    tb_clock_gen #(.period(clk_period)) u_clock (.clk(clk));

    noc_shim_loopback dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_word   (in_word),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_word  (out_word)
    );

    task automatic check_word(input axis_word_t got, input axis_word_t exp);
        if (got !== exp) begin
            word_errors++;
            $display("[FAIL] %0t: word %0d got data=%h dest=%h user=%h last=%b",
                     $time, received, got.data, got.dest, got.user, got.last);
            $display("[FAIL] %0t: word %0d expected data=%h dest=%h user=%h last=%b",
                     $time, received, exp.data, exp.dest, exp.user, exp.last);
        end
    endtask

    task automatic check_idle(input logic value, input string name);
        if (value !== 1'b0) begin
            idle_errors++;
            $display("[FAIL] %0t: %s is %b, expected 0", $time, name, value);
        end
    endtask

    task automatic make_word(output axis_word_t w);
        w.data = {$random(seed), $random(seed)};
        w.dest = 3'($random(seed));
        w.user = 8'($random(seed));
        w.last = 1'($random(seed));
    endtask

    task automatic report_other(input string msg);
        other_errors++;
        $display("Error at time %0t: %s", $time, msg);
    endtask

    initial begin
        #(watchdog_limit);
        $display("Timeout: only %0d of %0d words arrived in time", received, num_words);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        seed = 32'h63f9;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_word = '0;
        out_ready = 1'b0;
        offered = 0;
        sent = 0;
        received = 0;
        stall_left = 0;
        blocked_run = 0;
        last_set_seen = 0;
        last_clear_seen = 0;
        backpressure_seen = 1'b0;
        word_errors = 0;
        idle_errors = 0;
        other_errors = 0;

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Nothing may come out before any word went in
        repeat (3) begin
            @(negedge clk);
            check_idle(out_valid, "out_valid after reset");
        end

        while (received < num_words) begin
            @(negedge clk);
            in_fire  = in_valid && in_ready;
            out_fire = out_valid && out_ready;
            if (out_fire) begin
                if (model_q.size() == 0) begin
                    report_other("a word came out with no word outstanding");
                end else begin
                    expected = model_q.pop_front();
                    check_word(out_word, expected);
                end
                if (out_word.last) last_set_seen++;
                else last_clear_seen++;
                received++;
            end
            if (in_fire) begin
                model_q.push_back(in_word);
                sent++;
            end

            // A long unbroken refusal only comes from the stalled output
            if (in_valid && !in_ready) begin
                blocked_run++;
            end else begin
                blocked_run = 0;
            end
            if (stall_left > 0 && blocked_run >= blocked_limit) begin
                backpressure_seen = 1'b1;
            end

            @(posedge clk);
            #1;
            if (!in_valid || in_fire) begin
                if (offered < num_words && ($random(seed) & 3) != 0) begin
                    make_word(in_word);
                    in_valid = 1'b1;
                    offered++;
                end else begin
                    in_valid = 1'b0;
                end
            end

            // Drain with out_ready held high once every word is in
            if (offered == num_words && !in_valid) begin
                out_ready = 1'b1;
            end else if (stall_left > 0) begin
                out_ready = 1'b0;
                stall_left--;
            end else if (($random(seed) & 31) == 0) begin
                stall_left = 20 + ($random(seed) & 31);
                out_ready = 1'b0;
            end else begin
                out_ready = ($random(seed) & 3) != 0;
            end
        end

        @(negedge clk);
        check_idle(out_valid, "out_valid after drain");

        if (model_q.size() != 0) begin
            report_other($sformatf("%0d words were never delivered", model_q.size()));
        end
        if (sent != num_words) begin
            report_other($sformatf("%0d words accepted, expected %0d", sent, num_words));
        end
        if (last_set_seen == 0 || last_clear_seen == 0) begin
            report_other("output words did not cover both last values");
        end
        if (!backpressure_seen) begin
            report_other("in_ready never stayed low while the output was stalled");
        end

        $display("Errors: word %0d, idle %0d, other %0d", word_errors, idle_errors,
                 other_errors);
        if (word_errors + idle_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+src
src/noc_shim_pkg.sv
src/flit_fifo.sv
src/word_serializer.sv
src/flit_injector.sv
src/flit_ejector.sv
src/word_deserializer.sv
src/noc_shim_loopback.sv
sim/tb_clock_gen.sv
sim/noc_shim_assertions.sv
sim/noc_shim_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = noc_shim_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "*** TEST PASSED ***"

clean:
	rm -rf $(OBJ_DIR)
